/* src/fpPkg.sv */
/*
 * Shared single-precision format definitions for the nextafter unit.
 * Import into a module body to get the field widths, the word type and
 * the comparison result encoding.
 */

package fpPkg;

	// ========================================================================
	// Format geometry
	// ========================================================================

	// Top bit of a word, which also holds the sign
	localparam int wordMsb = 31;

	// Biased exponent width
	localparam int expBits = 8;

	// Stored fraction width, without the hidden bit
	localparam int fracBits = 23;

	// Exponent value reserved for infinity and NaN
	localparam logic [expBits-1:0] expMax = 8'hFF;

	// ========================================================================
	// Types
	// ========================================================================

	// Raw 32-bit word laid out as sign, exponent, fraction
	typedef logic [wordMsb:0] fpWord_t;

	// Outcome of ordering a against b
	// Unordered means at least one operand is a NaN
	typedef enum logic [1:0] {
		cmpLess      = 2'd0,
		cmpEqual     = 2'd1,
		cmpGreater   = 2'd2,
		cmpUnordered = 2'd3
	} cmpResult_t;

endpackage

/* src/fpDecomp.sv */
/*
 * Combinational field splitter for a single-precision word.
 * Gives the sign, exponent and fraction along with zero, infinity and
 * NaN class flags for use by the compare and nextafter logic.
 */
`timescale 1ns/10ps

module fpDecomp (
	input  fpPkg::fpWord_t                word,
	output logic                          sign,
	output logic [fpPkg::expBits-1:0]     exponent,
	output logic [fpPkg::fracBits-1:0]    fraction,
	output logic                          isZero,
	output logic                          isInf,
	output logic                          isNan
);
	import fpPkg::*;

	// Exponent is all zeros, so the word is a zero or a subnormal
	logic expZero;

	// Exponent is all ones, so the word is an infinity or a NaN
	logic expOnes;

	// No fraction bits set
	logic fracZero;

	// ========================================================================
	// Field extraction
	// ========================================================================

	// Sign lives in the top bit
	assign sign = word[wordMsb];

	// Exponent sits just below the sign
	assign exponent = word[wordMsb-1 -: expBits];

	// The fraction fills the low bits
	assign fraction = word[fracBits-1:0];

	// ========================================================================
	// Classification
	// ========================================================================

	assign expZero  = (exponent == '0);
	assign expOnes  = (exponent == expMax);
	assign fracZero = (fraction == '0);

	// Either sign of zero counts as zero
	assign isZero = expZero && fracZero;

	// Reserved exponent with an empty fraction is infinity
	assign isInf = expOnes && fracZero;

	// Any fraction bit under the reserved exponent makes a NaN
	// Quiet and signalling NaNs are not told apart here
	assign isNan = expOnes && !fracZero;

endmodule

/* src/fpCompare.sv */
/*
 * Combinational IEEE ordering of two single-precision words.
 * Returns less, equal, greater or unordered as seen from operand a.
 */
`timescale 1ns/10ps

module fpCompare (
	input  fpPkg::fpWord_t       a,
	input  fpPkg::fpWord_t       b,
	output fpPkg::cmpResult_t    result
);
	import fpPkg::*;

	// Fields and class flags of both operands
	logic                  signA;
	logic                  signB;
	logic [expBits-1:0]    expA;
	logic [expBits-1:0]    expB;
	logic [fracBits-1:0]   fracA;
	logic [fracBits-1:0]   fracB;
	logic                  zeroA;
	logic                  zeroB;
	logic                  nanA;
	logic                  nanB;

	// Magnitudes without the sign, which order like unsigned integers
	logic [wordMsb-1:0]    magA;
	logic [wordMsb-1:0]    magB;

	fpDecomp uDecompA (
		.word     (a),
		.sign     (signA),
		.exponent (expA),
		.fraction (fracA),
		.isZero   (zeroA),
		.isInf    (),
		.isNan    (nanA)
	);

	fpDecomp uDecompB (
		.word     (b),
		.sign     (signB),
		.exponent (expB),
		.fraction (fracB),
		.isZero   (zeroB),
		.isInf    (),
		.isNan    (nanB)
	);

	assign magA = {expA, fracA};
	assign magB = {expB, fracB};

	// ========================================================================
	// Ordering
	// ========================================================================

	always_comb begin
		if (nanA || nanB) begin
			// NaN compares with nothing
			result = cmpUnordered;
		end else if ((zeroA && zeroB) || (a == b)) begin
			// Both zeros are equal whatever their signs
			result = cmpEqual;
		end else if (signA != signB) begin
			// Mixed signs, so the negative operand is the smaller one
			result = signA ? cmpLess : cmpGreater;
		end else if (!signA) begin
			result = (magA < magB) ? cmpLess : cmpGreater;
		end else begin
			// Both negative, larger magnitude means smaller value
			result = (magA < magB) ? cmpGreater : cmpLess;
		end
	end

endmodule

/* src/fpNextAfter.sv */
/*
 * Registered nextafter stage. Each cycle with ce high it captures the next
 * representable value after a toward b, and raises outValid one cycle later.
 */
`timescale 1ns/10ps

module fpNextAfter (
	input  logic              clk,
	input  logic              rstN,
	input  logic              ce,
	input  fpPkg::fpWord_t    a,
	input  fpPkg::fpWord_t    b,
	output fpPkg::fpWord_t    o,
	output logic              outValid
);
	import fpPkg::*;

	// How a sits relative to b
	cmpResult_t cmp;

	// Class of operand a
	logic aSign;
	logic aZero;
	logic aNan;

	// High when the step moves a away from zero
	logic stepUp;

	// Neighbouring bit patterns of a
	fpWord_t aUp;
	fpWord_t aDown;

	// Smallest subnormal carrying the sign of b
	fpWord_t minSub;

	// Combinational result before the output register
	fpWord_t nextWord;

	// ========================================================================
	// Operand analysis
	// ========================================================================

	fpCompare uCompare (
		.a      (a),
		.b      (b),
		.result (cmp)
	);

	fpDecomp uDecompA (
		.word     (a),
		.sign     (aSign),
		.exponent (),
		.fraction (),
		.isZero   (aZero),
		.isInf    (),
		.isNan    (aNan)
	);

	// Positive a heading up or negative a heading down grows the magnitude
	assign stepUp = (!aSign && (cmp == cmpLess)) || (aSign && (cmp == cmpGreater));

	// Adjacent patterns are adjacent values for a fixed sign
	// The carry out of the largest finite pattern lands on infinity,
	// and infinity minus one is the largest finite number
	assign aUp   = a + fpWord_t'(1);
	assign aDown = a - fpWord_t'(1);

	assign minSub = {b[wordMsb], {(wordMsb - 1){1'b0}}, 1'b1};

	// ========================================================================
	// Result selection
	// ========================================================================

	always_comb begin
		if (cmp == cmpUnordered) begin
			// Pass the NaN through, a first
			nextWord = aNan ? a : b;
		end else if (cmp == cmpEqual) begin
			nextWord = a;
		end else if (aZero) begin
			// Zero of either sign steps out to the smallest subnormal
			nextWord = minSub;
		end else begin
			nextWord = stepUp ? aUp : aDown;
		end
	end

	// ========================================================================
	// Output register
	// ========================================================================

	always_ff @(posedge clk) begin
		if (!rstN) begin
			o        <= '0;
			outValid <= 1'b0;
		end else begin
			// The strobe follows ce every cycle, so each input appears once
			outValid <= ce;
			if (ce) begin
				o <= nextWord;
			end
		end
	end

endmodule

/* src/fpNextUnit.sv */
/*
 * Top level of the nextafter unit. An input strobe with a and b produces
 * an output strobe with the result exactly one cycle later.
 */
`timescale 1ns/10ps

module fpNextUnit (
	input  logic              clk,
	input  logic              rstN,
	input  logic              inValid,
	input  fpPkg::fpWord_t    a,
	input  fpPkg::fpWord_t    b,
	output logic              outValid,
	output fpPkg::fpWord_t    o
);
	import fpPkg::*;

	// Result straight from the stage register
	fpWord_t stageOut;

	// Strobe straight from the stage register
	logic stageValid;

	// ========================================================================
	// Single pipeline stage
	// ========================================================================

	// The input strobe acts as the clock enable, since nothing stalls
	fpNextAfter uNextAfter (
		.clk      (clk),
		.rstN     (rstN),
		.ce       (inValid),
		.a        (a),
		.b        (b),
		.o        (stageOut),
		.outValid (stageValid)
	);

	// Both outputs come directly from registers in the stage
	assign o        = stageOut;
	assign outValid = stageValid;

endmodule

/* tb/fpNextUnit_assert.sv */
/*
 * Concurrent checks on the strobe timing and reset of the nextafter unit.
 * Bound into every fpNextUnit instance.
 */
`timescale 1ns/10ps

module fpNextUnit_assert (
	input logic           clk,
	input logic           rstN,
	input logic           inValid,
	input logic           outValid,
	input fpPkg::fpWord_t o
);

	// An input strobe always gives an output strobe on the next cycle
	validFollows: assert property (@(posedge clk) disable iff (!rstN) inValid |=> outValid)
		else $error("outValid did not follow inValid");

	// No output strobe without an input strobe one cycle before
	noStrayValid: assert property (@(posedge clk) disable iff (!rstN) !inValid |=> !outValid)
		else $error("outValid rose without an input strobe");

	// Reset clears the strobe at the following edge
	resetClears: assert property (@(posedge clk) !rstN |=> !outValid)
		else $error("outValid was high after a reset cycle");

	// The result register holds while no strobe is present
	holdResult: assert property (@(posedge clk) disable iff (!rstN) !inValid |=> $stable(o))
		else $error("o changed without an input strobe");

endmodule

bind fpNextUnit fpNextUnit_assert uAssert (
	.clk      (clk),
	.rstN     (rstN),
	.inValid  (inValid),
	.outValid (outValid),
	.o        (o)
);

/* tb/tb_fpNextUnit.sv */
/*
 * Testbench for the nextafter unit. Reads a, b and the expected result
 * from the cases file, drives strobes with and without idle gaps, and
 * checks every output word and the strobe timing.
 */
`timescale 1ns/10ps

module tb_fpNextUnit;
	import fpPkg::*;

	logic    clk;
	logic    rstN;
	logic    inValid;
	fpWord_t a;
	fpWord_t b;
	logic    outValid;
	fpWord_t o;

	// Case table loaded from the data file
	fpWord_t caseA [$];
	fpWord_t caseB [$];
	fpWord_t caseO [$];

	// Results expected from strobes already sent, oldest first
	fpWord_t expQ [$];

	int   numCases;
	int   checkedCount;
	int   cycleCount;
	int   cycleLimit;
	int   gap;
	int   seed;
	logic lastStrobe;

	fpNextUnit u_fpNextUnit (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.a        (a),
		.b        (b),
		.outValid (outValid),
		.o        (o)
	);

	// ========================================================================
	// Failure reporting and checks
	// ========================================================================

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic checkWord(input fpWord_t got, input fpWord_t exp);
		if (got !== exp) begin
			failNow($sformatf("mismatch time=%0t signal=o got=%h expected=%h",
				$time, got, exp));
		end
	endtask

	task automatic checkValid(input logic got, input logic exp);
		if (got !== exp) begin
			failNow($sformatf("mismatch time=%0t signal=outValid got=%b expected=%b",
				$time, got, exp));
		end
	endtask

	// Lines that do not hold three hex words are skipped as comments
	task automatic loadCases();
		int      fd;
		string   line;
		fpWord_t ca;
		fpWord_t cb;
		fpWord_t co;
		fd = $fopen("tb/nextafter_cases.txt", "r");
		if (fd == 0) begin
			failNow("Could not open the cases file tb/nextafter_cases.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if ($sscanf(line, "%h %h %h", ca, cb, co) == 3) begin
				caseA.push_back(ca);
				caseB.push_back(cb);
				caseO.push_back(co);
			end
		end
		$fclose(fd);
		numCases = caseA.size();
		if (numCases == 0) begin
			failNow("The cases file holds no test vectors");
		end
	endtask

	// ========================================================================
	// Clock, watchdog and output monitor
	// ========================================================================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			failNow($sformatf("Timeout: the run did not finish within %0d cycles",
				cycleLimit));
		end
	end

	// Sampled mid-cycle, where the registered outputs are settled
	always @(negedge clk) begin
		checkValid(outValid, lastStrobe);
		if (outValid) begin
			if (expQ.size() == 0) begin
				failNow("An output strobe arrived with no case pending");
			end else begin
				checkWord(o, expQ.pop_front());
				checkedCount++;
			end
		end
		// The strobe seen now is captured at the coming edge
		lastStrobe = inValid && rstN;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================

	initial begin
		rstN = 1'b0;
		inValid = 1'b0;
		a = '0;
		b = '0;
		seed = 72;
		lastStrobe = 1'b0;
		checkedCount = 0;
		cycleCount = 0;
		cycleLimit = 50;
		loadCases();
		cycleLimit = numCases * 20 + 50;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		for (int i = 0; i < numCases; i++) begin
			@(posedge clk);
			#1;
			inValid = 1'b1;
			a = caseA[i];
			b = caseB[i];
			expQ.push_back(caseO[i]);
			// First half goes back to back, the rest with random idle gaps
			gap = (i < numCases / 2) ? 0 : ($random(seed) & 3);
			repeat (gap) begin
				@(posedge clk);
				#1 inValid = 1'b0;
			end
		end
		@(posedge clk);
		#1 inValid = 1'b0;
		wait (checkedCount == numCases);
		// A few idle cycles let the monitor catch any stray strobe
		repeat (3) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

/* tb/nextafter_cases.txt */
// Columns: a b expected_o, all as 32-bit hex words
// Lines that start with // are skipped
3F800000 40000000 3F800001
3F800000 00000000 3F7FFFFF
BF800000 C0000000 BF800001
BF800000 3F800000 BF7FFFFF
00800000 00000000 007FFFFF
80800000 00000000 807FFFFF
40490FDB 3F800000 40490FDA
00000001 00000000 00000000
00000000 3F800000 00000001
00000000 BF800000 80000001
80000000 3F800000 00000001
80000000 BF800000 80000001
00000000 80000000 00000000
7F7FFFFF 7F800000 7F800000
7F800000 3F800000 7F7FFFFF
FF800000 00000000 FF7FFFFF
FF7FFFFF FF800000 FF800000
7FC00000 3F800000 7FC00000
7F800001 3F800000 7F800001
3F800000 7FC00001 7FC00001
FFC00000 7FC00000 FFC00000
3F800000 3F800000 3F800000
C2280000 C2280000 C2280000
7F800000 7F800000 7F800000

/* project.f */
src/fpPkg.sv
src/fpDecomp.sv
src/fpCompare.sv
src/fpNextAfter.sv
src/fpNextUnit.sv
tb/fpNextUnit_assert.sv
tb/tb_fpNextUnit.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the nextafter unit and its testbench with Verilator, then run it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_fpNextUnit \
	-f project.f \
	-o simv

# A failing run exits nonzero, so keep going and let the log decide
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
